/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_proc
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qxF '** PASS **' $(LOG); then echo "Test passed"; \
	else echo "Test failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	localparam int DATA_WIDTH = 16;
	localparam int REG_COUNT = 8;
	localparam int REG_SEL_WIDTH = 3;
	localparam int DATA_WORDS = 16;
	localparam int DATA_ADDR_WIDTH = $clog2(DATA_WORDS);
	localparam int PC_STEP = 2;

	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [REG_SEL_WIDTH-1:0] reg_sel_t;
	typedef logic [4:0] opcode_t;
	typedef logic [1:0] funct_t;

	localparam opcode_t OP_HALT = 5'b00000;
	localparam opcode_t OP_NOP = 5'b00001;
	localparam opcode_t OP_ADDI = 5'b01000;
	localparam opcode_t OP_ST = 5'b10000;
	localparam opcode_t OP_LD = 5'b10001;
	localparam opcode_t OP_LBI = 5'b11000;
	localparam opcode_t OP_ALU = 5'b11011;

	// Register-register group, selected by funct
	localparam funct_t FN_ADD = 2'd0;
	localparam funct_t FN_SUB = 2'd1;
	localparam funct_t FN_XOR = 2'd2;
	localparam funct_t FN_ANDN = 2'd3;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_ANDN,
		ALU_PASS
	} alu_op_t;

	typedef struct packed {
		opcode_t opcode;
		reg_sel_t rs;
		reg_sel_t rt;
		reg_sel_t rd;
		funct_t funct;
	} instr_t;

	// Immediates overlap the low register fields
	function automatic word_t sext_imm5(instr_t word);
		logic [4:0] imm;
		imm = {word.rd, word.funct};
		return {{(DATA_WIDTH-5){imm[4]}}, imm};
	endfunction

	function automatic word_t sext_imm8(instr_t word);
		logic [7:0] imm;
		imm = {word.rt, word.rd, word.funct};
		return {{(DATA_WIDTH-8){imm[7]}}, imm};
	endfunction

endpackage

`default_nettype wire

/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	typedef struct packed {
		logic reg_write;
		isa_pkg::reg_sel_t dest;
		isa_pkg::alu_op_t alu_op;
		logic use_imm;
		logic mem_read;
		logic mem_write;
		logic is_halt;
	} ctrl_t;

	// Decode to execute
	typedef struct packed {
		ctrl_t ctrl;
		isa_pkg::reg_sel_t rs;
		isa_pkg::reg_sel_t rt;
		isa_pkg::word_t op_a;
		isa_pkg::word_t op_b;
		isa_pkg::word_t imm;
	} id_ex_t;

	// Execute to memory
	typedef struct packed {
		logic reg_write;
		isa_pkg::reg_sel_t dest;
		logic mem_read;
		logic mem_write;
		logic is_halt;
		isa_pkg::word_t result;
		isa_pkg::word_t store_data;
	} ex_mem_t;

	// Memory to writeback
	typedef struct packed {
		logic reg_write;
		isa_pkg::reg_sel_t dest;
		logic is_halt;
		isa_pkg::word_t data;
	} mem_wb_t;

	typedef struct packed {
		logic valid;
		isa_pkg::reg_sel_t dest;
		isa_pkg::word_t data;
	} wb_t;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

endpackage

`default_nettype wire

/* decode/decode_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
	input  isa_pkg::instr_t instr,
	output pipe_pkg::ctrl_t ctrl,
	output logic            illegal
);

	always_comb begin
		// NOP control unless the opcode says otherwise
		ctrl = '0;
		ctrl.alu_op = isa_pkg::ALU_ADD;
		illegal = 1'b0;
		case (instr.opcode)
			isa_pkg::OP_HALT: begin
				ctrl.is_halt = 1'b1;
			end
			isa_pkg::OP_NOP: begin
				ctrl.reg_write = 1'b0;
			end
			isa_pkg::OP_ADDI: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest = instr.rt;
				ctrl.use_imm = 1'b1;
			end
			isa_pkg::OP_ST: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			isa_pkg::OP_LD: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest = instr.rt;
				ctrl.use_imm = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			isa_pkg::OP_LBI: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest = instr.rs;
				ctrl.alu_op = isa_pkg::ALU_PASS;
				ctrl.use_imm = 1'b1;
			end
			isa_pkg::OP_ALU: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest = instr.rd;
				case (instr.funct)
					isa_pkg::FN_ADD:  ctrl.alu_op = isa_pkg::ALU_ADD;
					isa_pkg::FN_SUB:  ctrl.alu_op = isa_pkg::ALU_SUB;
					isa_pkg::FN_XOR:  ctrl.alu_op = isa_pkg::ALU_XOR;
					default:          ctrl.alu_op = isa_pkg::ALU_ANDN;
				endcase
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic              clk,
	input  logic              reset,
	input  isa_pkg::reg_sel_t read_sel_a,
	input  isa_pkg::reg_sel_t read_sel_b,
	output isa_pkg::word_t    read_a,
	output isa_pkg::word_t    read_b,
	input  logic              write_en,
	input  isa_pkg::reg_sel_t write_sel,
	input  isa_pkg::word_t    write_data
);

	isa_pkg::word_t regs [isa_pkg::REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < isa_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_sel] <= write_data;
		end
	end

	// Write-through covers the distance-3 producer
	assign read_a = (write_en && write_sel == read_sel_a) ? write_data : regs[read_sel_a];
	assign read_b = (write_en && write_sel == read_sel_b) ? write_data : regs[read_sel_b];

endmodule

`default_nettype wire

/* flist.f */
common/isa_pkg.sv
common/pipe_pkg.sv
source/pipe_reg.sv
decode/decode_ctrl.sv
decode/reg_file.sv
source/hazard_unit.sv
source/execute_stage.sv
source/data_mem.sv
source/proc.sv
testbench/clock_gen.sv
testbench/tb_proc.sv

/* source/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [isa_pkg::DATA_ADDR_WIDTH-1:0] addr,
	input  logic                                write_en,
	input  isa_pkg::word_t                      write_data,
	output isa_pkg::word_t                      read_data
);

	isa_pkg::word_t mem [isa_pkg::DATA_WORDS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < isa_pkg::DATA_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (write_en) begin
			mem[addr] <= write_data;
		end
	end

	assign read_data = mem[addr];

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  pipe_pkg::id_ex_t   stage,
	input  pipe_pkg::fwd_sel_t fwd_a,
	input  pipe_pkg::fwd_sel_t fwd_b,
	input  isa_pkg::word_t     mem_result,
	input  isa_pkg::word_t     wb_result,
	output pipe_pkg::ex_mem_t  result
);

	isa_pkg::word_t op_a;
	isa_pkg::word_t op_b;
	isa_pkg::word_t alu_b;
	isa_pkg::word_t alu_out;

	function automatic isa_pkg::word_t select_operand(
		pipe_pkg::fwd_sel_t sel,
		isa_pkg::word_t reg_value,
		isa_pkg::word_t from_mem,
		isa_pkg::word_t from_wb
	);
		case (sel)
			pipe_pkg::FWD_MEM: return from_mem;
			pipe_pkg::FWD_WB:  return from_wb;
			default:           return reg_value;
		endcase
	endfunction

	assign op_a = select_operand(fwd_a, stage.op_a, mem_result, wb_result);
	assign op_b = select_operand(fwd_b, stage.op_b, mem_result, wb_result);
	assign alu_b = stage.ctrl.use_imm ? stage.imm : op_b;

	// SUB is rt minus rs
	always_comb begin
		case (stage.ctrl.alu_op)
			isa_pkg::ALU_ADD:  alu_out = op_a + alu_b;
			isa_pkg::ALU_SUB:  alu_out = alu_b - op_a;
			isa_pkg::ALU_XOR:  alu_out = op_a ^ alu_b;
			isa_pkg::ALU_ANDN: alu_out = op_a & ~alu_b;
			default:           alu_out = stage.imm;
		endcase
	end

	// Loads and stores use the add path for the address
	always_comb begin
		result.reg_write = stage.ctrl.reg_write;
		result.dest = stage.ctrl.dest;
		result.mem_read = stage.ctrl.mem_read;
		result.mem_write = stage.ctrl.mem_write;
		result.is_halt = stage.ctrl.is_halt;
		result.result = alu_out;
		result.store_data = op_b;
	end

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  isa_pkg::reg_sel_t  id_rs,
	input  isa_pkg::reg_sel_t  id_rt,
	input  isa_pkg::reg_sel_t  ex_rs,
	input  isa_pkg::reg_sel_t  ex_rt,
	input  pipe_pkg::ctrl_t    ex_ctrl,
	input  logic               ex_valid,
	input  isa_pkg::reg_sel_t  mem_dest,
	input  logic               mem_write_en,
	input  isa_pkg::reg_sel_t  wb_dest,
	input  logic               wb_write_en,
	output pipe_pkg::fwd_sel_t fwd_a,
	output pipe_pkg::fwd_sel_t fwd_b,
	output logic               stall
);

	// Memory stage is younger, so it wins over writeback
	function automatic pipe_pkg::fwd_sel_t pick_source(
		isa_pkg::reg_sel_t src,
		isa_pkg::reg_sel_t m_dest,
		logic m_we,
		isa_pkg::reg_sel_t w_dest,
		logic w_we
	);
		if (m_we && m_dest == src) begin
			return pipe_pkg::FWD_MEM;
		end else if (w_we && w_dest == src) begin
			return pipe_pkg::FWD_WB;
		end
		return pipe_pkg::FWD_REG;
	endfunction

	assign fwd_a = pick_source(ex_rs, mem_dest, mem_write_en, wb_dest, wb_write_en);
	assign fwd_b = pick_source(ex_rt, mem_dest, mem_write_en, wb_dest, wb_write_en);

	// Load data is not ready until the memory stage
	assign stall = ex_valid && ex_ctrl.mem_read && ex_ctrl.reg_write &&
		(ex_ctrl.dest == id_rs || ex_ctrl.dest == id_rt);

endmodule

`default_nettype wire

/* source/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     enable,
	input  logic     flush,
	input  payload_t d,
	input  logic     d_valid,
	output payload_t q,
	output logic     q_valid
);

	// Valid bit is the only control state
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q_valid <= 1'b0;
		end else if (enable) begin
			q_valid <= d_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (enable) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

/* source/proc.sv */
`timescale 1ns/1ps
`default_nettype none

module proc (
	input  logic           clk,
	input  logic           reset,
	output isa_pkg::word_t pc,
	input  isa_pkg::word_t instr,
	output pipe_pkg::wb_t  wb,
	output logic           halted,
	output logic           err
);

	isa_pkg::instr_t if_id;
	logic if_id_valid;
	pipe_pkg::ctrl_t id_ctrl;
	logic id_illegal;
	isa_pkg::word_t id_read_a;
	isa_pkg::word_t id_read_b;
	pipe_pkg::id_ex_t id_stage;
	pipe_pkg::id_ex_t id_ex;
	logic id_ex_valid;
	pipe_pkg::ex_mem_t ex_result;
	pipe_pkg::ex_mem_t ex_mem;
	logic ex_mem_valid;
	isa_pkg::word_t mem_read_data;
	pipe_pkg::mem_wb_t mem_stage;
	pipe_pkg::mem_wb_t mem_wb;
	logic mem_wb_valid;
	pipe_pkg::fwd_sel_t fwd_a;
	pipe_pkg::fwd_sel_t fwd_b;
	logic stall;
	logic id_halt;
	logic fetch_stop;
	logic halted_q;
	logic pc_en;
	logic mem_reg_write;
	logic wb_reg_write;

	// Fetch stops for a load-use stall and for good once HALT is decoded
	assign id_halt = if_id_valid && id_ctrl.is_halt;
	assign pc_en = !stall && !id_halt && !fetch_stop;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			fetch_stop <= 1'b0;
			halted_q <= 1'b0;
			err <= 1'b0;
		end else begin
			if (pc_en) begin
				pc <= pc + isa_pkg::word_t'(isa_pkg::PC_STEP);
			end
			if (id_halt && !stall) begin
				fetch_stop <= 1'b1;
			end
			if (mem_wb_valid && mem_wb.is_halt) begin
				halted_q <= 1'b1;
			end
			if (if_id_valid && id_illegal) begin
				err <= 1'b1;
			end
		end
	end

	assign halted = halted_q || (mem_wb_valid && mem_wb.is_halt);

	// HALT leaves decode once, then IF/ID stays empty
	pipe_reg #(.payload_t(isa_pkg::instr_t)) i_if_id (
		.clk     (clk),
		.reset   (reset),
		.enable  (!stall && !fetch_stop),
		.flush   (id_halt && !stall),
		.d       (isa_pkg::instr_t'(instr)),
		.d_valid (1'b1),
		.q       (if_id),
		.q_valid (if_id_valid)
	);

	decode_ctrl i_decode_ctrl (
		.instr   (if_id),
		.ctrl    (id_ctrl),
		.illegal (id_illegal)
	);

	reg_file i_reg_file (
		.clk        (clk),
		.reset      (reset),
		.read_sel_a (if_id.rs),
		.read_sel_b (if_id.rt),
		.read_a     (id_read_a),
		.read_b     (id_read_b),
		.write_en   (wb_reg_write),
		.write_sel  (mem_wb.dest),
		.write_data (mem_wb.data)
	);

	always_comb begin
		id_stage.ctrl = id_ctrl;
		id_stage.rs = if_id.rs;
		id_stage.rt = if_id.rt;
		id_stage.op_a = id_read_a;
		id_stage.op_b = id_read_b;
		// LBI is the only user of the 8-bit immediate
		if (id_ctrl.alu_op == isa_pkg::ALU_PASS) begin
			id_stage.imm = isa_pkg::sext_imm8(if_id);
		end else begin
			id_stage.imm = isa_pkg::sext_imm5(if_id);
		end
	end

	hazard_unit i_hazard_unit (
		.id_rs        (if_id.rs),
		.id_rt        (if_id.rt),
		.ex_rs        (id_ex.rs),
		.ex_rt        (id_ex.rt),
		.ex_ctrl      (id_ex.ctrl),
		.ex_valid     (id_ex_valid),
		.mem_dest     (ex_mem.dest),
		.mem_write_en (mem_reg_write),
		.wb_dest      (mem_wb.dest),
		.wb_write_en  (wb_reg_write),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.stall        (stall)
	);

	// Bubble into execute while decode waits on a load
	pipe_reg #(.payload_t(pipe_pkg::id_ex_t)) i_id_ex (
		.clk     (clk),
		.reset   (reset),
		.enable  (1'b1),
		.flush   (stall),
		.d       (id_stage),
		.d_valid (if_id_valid),
		.q       (id_ex),
		.q_valid (id_ex_valid)
	);

	execute_stage i_execute_stage (
		.stage      (id_ex),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b),
		.mem_result (mem_stage.data),
		.wb_result  (mem_wb.data),
		.result     (ex_result)
	);

	pipe_reg #(.payload_t(pipe_pkg::ex_mem_t)) i_ex_mem (
		.clk     (clk),
		.reset   (reset),
		.enable  (1'b1),
		.flush   (1'b0),
		.d       (ex_result),
		.d_valid (id_ex_valid),
		.q       (ex_mem),
		.q_valid (ex_mem_valid)
	);

	assign mem_reg_write = ex_mem_valid && ex_mem.reg_write;

	data_mem i_data_mem (
		.clk        (clk),
		.reset      (reset),
		.addr       (ex_mem.result[isa_pkg::DATA_ADDR_WIDTH-1:0]),
		.write_en   (ex_mem_valid && ex_mem.mem_write),
		.write_data (ex_mem.store_data),
		.read_data  (mem_read_data)
	);

	always_comb begin
		mem_stage.reg_write = ex_mem.reg_write;
		mem_stage.dest = ex_mem.dest;
		mem_stage.is_halt = ex_mem.is_halt;
		mem_stage.data = ex_mem.mem_read ? mem_read_data : ex_mem.result;
	end

	pipe_reg #(.payload_t(pipe_pkg::mem_wb_t)) i_mem_wb (
		.clk     (clk),
		.reset   (reset),
		.enable  (1'b1),
		.flush   (1'b0),
		.d       (mem_stage),
		.d_valid (ex_mem_valid),
		.q       (mem_wb),
		.q_valid (mem_wb_valid)
	);

	assign wb_reg_write = mem_wb_valid && mem_wb.reg_write;

	assign wb.valid = wb_reg_write;
	assign wb.dest = mem_wb.dest;
	assign wb.data = mem_wb.data;

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int HALF_PERIOD = 4,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Released on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/tb_proc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_proc;

	localparam int PROG_LEN = 200;
	localparam int PROG_WORDS = PROG_LEN + 1;
	localparam int RUN_CYCLES = PROG_WORDS * 3 + 20;
	localparam int RESET_CYCLES = 2;
	localparam int TAIL_CYCLES = 8;
	localparam int MID_RUN_CYCLES = 60;
	localparam int RUN_COUNT = 3;
	localparam int WATCHDOG_CYCLES = RUN_COUNT * RUN_CYCLES + MID_RUN_CYCLES;
	localparam isa_pkg::word_t NOP_WORD = {isa_pkg::OP_NOP, 11'd0};
	localparam isa_pkg::word_t HALT_WORD = {isa_pkg::OP_HALT, 11'd0};
	localparam isa_pkg::word_t FILL_WORD = {isa_pkg::OP_LBI, 3'd1, 8'h5a};
	localparam isa_pkg::opcode_t BAD_OPCODE = 5'b11111;

	typedef struct packed {
		isa_pkg::reg_sel_t dest;
		isa_pkg::word_t data;
	} reg_write_t;

	logic clk;
	logic por_reset;
	logic restart;
	logic reset;
	isa_pkg::word_t pc;
	isa_pkg::word_t instr;
	pipe_pkg::wb_t wb;
	logic halted;
	logic err;

	isa_pkg::word_t program_words [PROG_WORDS];
	isa_pkg::word_t model_regs [isa_pkg::REG_COUNT];
	isa_pkg::word_t model_mem [isa_pkg::DATA_WORDS];
	reg_write_t expected [$];
	int expected_index;
	bit checking;
	bit halted_seen;
	bit err_seen;
	isa_pkg::word_t halted_pc;
	int value_errors;
	int other_errors;

	assign reset = por_reset || restart;

	clock_gen #(.HALF_PERIOD(4), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
		.clk   (clk),
		.reset (por_reset)
	);

	proc i_proc (
		.clk    (clk),
		.reset  (reset),
		.pc     (pc),
		.instr  (instr),
		.wb     (wb),
		.halted (halted),
		.err    (err)
	);

	function automatic isa_pkg::word_t encode(isa_pkg::opcode_t opcode, isa_pkg::reg_sel_t rs,
		isa_pkg::reg_sel_t rt, logic [4:0] low);
		return {opcode, rs, rt, low};
	endfunction

	function automatic isa_pkg::word_t extend5(logic [4:0] imm);
		return {{11{imm[4]}}, imm};
	endfunction

	function automatic isa_pkg::word_t extend8(logic [7:0] imm);
		return {{8{imm[7]}}, imm};
	endfunction

	// Past the HALT the fetch sees register writes that must never retire
	function automatic isa_pkg::word_t fetch_word(isa_pkg::word_t addr);
		int index;
		index = int'(addr) / isa_pkg::PC_STEP;
		if (index < PROG_WORDS) begin
			return program_words[index];
		end
		return FILL_WORD;
	endfunction

	task automatic make_program(input bit with_illegal);
		int kind;
		int illegal_at;
		isa_pkg::opcode_t opcode;
		isa_pkg::reg_sel_t rs;
		isa_pkg::reg_sel_t rt;
		logic [4:0] low;
		isa_pkg::reg_sel_t load_dest;
		bit after_load;
		illegal_at = with_illegal ? 20 + int'($urandom % (PROG_LEN - 40)) : -1;
		after_load = 1'b0;
		load_dest = '0;
		for (int i = 0; i < PROG_LEN; i++) begin
			kind = int'($urandom % 10);
			rs = isa_pkg::reg_sel_t'($urandom);
			rt = isa_pkg::reg_sel_t'($urandom);
			low = 5'($urandom);
			case (kind)
				0: opcode = isa_pkg::OP_NOP;
				1, 2: opcode = isa_pkg::OP_ADDI;
				3: opcode = isa_pkg::OP_LBI;
				4: opcode = isa_pkg::OP_ST;
				5, 6: opcode = isa_pkg::OP_LD;
				default: opcode = isa_pkg::OP_ALU;
			endcase
			if (i == illegal_at) begin
				opcode = BAD_OPCODE;
			end else if (after_load && kind < 4) begin
				// Load result used by the very next instruction
				opcode = isa_pkg::OP_ALU;
				rs = load_dest;
			end
			program_words[i] = encode(opcode, rs, rt, low);
			after_load = (opcode == isa_pkg::OP_LD);
			load_dest = rt;
		end
		program_words[PROG_LEN] = HALT_WORD;
	endtask

	task automatic retire(isa_pkg::reg_sel_t dest, isa_pkg::word_t value);
		reg_write_t entry;
		model_regs[dest] = value;
		entry.dest = dest;
		entry.data = value;
		expected.push_back(entry);
	endtask

	// In-order ISA model from cleared registers and memory
	task automatic build_expected();
		isa_pkg::word_t word;
		isa_pkg::word_t a;
		isa_pkg::word_t b;
		isa_pkg::word_t sum;
		int addr;
		expected.delete();
		for (int r = 0; r < isa_pkg::REG_COUNT; r++) begin
			model_regs[r] = '0;
		end
		for (int m = 0; m < isa_pkg::DATA_WORDS; m++) begin
			model_mem[m] = '0;
		end
		for (int i = 0; i < PROG_WORDS; i++) begin
			word = program_words[i];
			if (word[15:11] == isa_pkg::OP_HALT) begin
				break;
			end
			a = model_regs[word[10:8]];
			b = model_regs[word[7:5]];
			sum = a + extend5(word[4:0]);
			addr = int'(sum) % isa_pkg::DATA_WORDS;
			case (word[15:11])
				isa_pkg::OP_ADDI: retire(word[7:5], sum);
				isa_pkg::OP_LBI: retire(word[10:8], extend8(word[7:0]));
				isa_pkg::OP_ST: model_mem[addr] = b;
				isa_pkg::OP_LD: retire(word[7:5], model_mem[addr]);
				isa_pkg::OP_ALU: begin
					case (word[1:0])
						isa_pkg::FN_ADD: retire(word[4:2], a + b);
						isa_pkg::FN_SUB: retire(word[4:2], b - a);
						isa_pkg::FN_XOR: retire(word[4:2], a ^ b);
						default: retire(word[4:2], a & ~b);
					endcase
				end
				default: begin
				end
			endcase
		end
	endtask

	task automatic check_outputs();
		reg_write_t want;
		if (wb.valid) begin
			assert (expected_index < expected.size()) else begin
				$display("Unexpected writeback of r%0d = %h at %0t, beyond the model's last write",
					wb.dest, wb.data, $time);
				other_errors++;
			end
			if (expected_index < expected.size()) begin
				want = expected[expected_index];
				assert (wb.dest == want.dest && wb.data == want.data) else begin
					$display("CHECK FAILED at %0t: write %0d is r%0d = %h, expected r%0d = %h",
						$time, expected_index, wb.dest, wb.data, want.dest, want.data);
					value_errors++;
				end
				expected_index++;
			end
		end
		if (halted_seen) begin
			assert (halted && pc == halted_pc) else begin
				$display("CHECK FAILED at %0t: halted %b pc %h after halt at pc %h",
					$time, halted, pc, halted_pc);
				value_errors++;
			end
		end else if (halted) begin
			halted_seen = 1'b1;
			halted_pc = pc;
		end
		if (err_seen) begin
			assert (err) else begin
				$display("CHECK FAILED at %0t: err dropped without reset", $time);
				value_errors++;
			end
		end else if (err) begin
			err_seen = 1'b1;
		end
	endtask

	task automatic step();
		@(negedge clk);
		if (checking) begin
			check_outputs();
		end
		instr = fetch_word(pc);
	endtask

	task automatic check_after_reset();
		assert (pc == '0 && !wb.valid && !halted && !err) else begin
			$display("CHECK FAILED at %0t: after reset pc %h valid %b halted %b err %b",
				$time, pc, wb.valid, halted, err);
			value_errors++;
		end
		expected_index = 0;
		halted_seen = 1'b0;
		err_seen = 1'b0;
		checking = 1'b1;
	endtask

	// Called at a falling edge
	task automatic apply_reset();
		checking = 1'b0;
		restart = 1'b1;
		repeat (RESET_CYCLES) step();
		restart = 1'b0;
		check_after_reset();
	endtask

	task automatic run_to_halt();
		while (!halted_seen) begin
			step();
		end
		repeat (TAIL_CYCLES) step();
	endtask

	task automatic finish_run(input bit expect_err);
		assert (expected_index == expected.size()) else begin
			$display("CHECK FAILED at %0t: %0d writebacks, model expects %0d",
				$time, expected_index, expected.size());
			value_errors++;
		end
		assert (err == expect_err) else begin
			$display("CHECK FAILED at %0t: err is %b, expected %b", $time, err, expect_err);
			value_errors++;
		end
	endtask

	initial begin
		void'($urandom(32'h6f1f));
		restart = 1'b0;
		instr = NOP_WORD;
		checking = 1'b0;
		halted_seen = 1'b0;
		err_seen = 1'b0;
		halted_pc = '0;
		expected_index = 0;
		value_errors = 0;
		other_errors = 0;

		make_program(1'b0);
		build_expected();
		@(negedge por_reset);
		check_after_reset();
		instr = fetch_word(pc);
		run_to_halt();
		finish_run(1'b0);

		// One illegal opcode somewhere in the middle
		make_program(1'b1);
		build_expected();
		apply_reset();
		run_to_halt();
		finish_run(1'b1);

		// Reset partway through and rerun the same program from a clean state
		make_program(1'b0);
		build_expected();
		apply_reset();
		repeat (MID_RUN_CYCLES) step();
		apply_reset();
		build_expected();
		run_to_halt();
		finish_run(1'b0);

		$display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the processor did not finish the programs within %0d cycles",
			WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
